// ==== build.f ====
+incdir+tb
common/isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/hazard_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

// ==== common/isa_pkg.sv ====
package isa_pkg;

   localparam int REG_COUNT = 32;

   typedef logic [31:0]                  word_t;
   typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

   // Primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_SLTI  = 6'h0a;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_XORI  = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // Function codes under OP_RTYPE
   localparam logic [5:0] FN_SLL  = 6'h00;
   localparam logic [5:0] FN_SRL  = 6'h02;
   localparam logic [5:0] FN_SRA  = 6'h03;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;
   localparam logic [5:0] FN_SLT  = 6'h2a;
   localparam logic [5:0] FN_SLTU = 6'h2b;

   typedef struct packed {
      logic [5:0] op;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]  op;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
   } i_fmt_t;

   // Same word seen as R or I format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   typedef enum logic [1:0] {
      MEM_NONE,
      MEM_LOAD,
      MEM_STORE
   } mem_kind_e;

   // Where a decode operand comes from
   typedef enum logic [1:0] {
      FWD_REGFILE,
      FWD_EX,
      FWD_MEM
   } fwd_sel_e;

endpackage

// ==== decode/decode_stage.sv ====
module decode_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      stall_i,
   input  word_t     pc_i,
   input  word_t     instr_i,
   input  word_t     rs_data_i,
   input  word_t     rt_data_i,
   input  word_t     ex_fwd_i,
   input  word_t     mem_fwd_i,
   input  fwd_sel_e  fwd_a_sel_i,
   input  fwd_sel_e  fwd_b_sel_i,
   output reg_idx_t  rs_o,
   output reg_idx_t  rt_o,
   output word_t     ex_pc_o,
   output alu_op_e   ex_alu_op_o,
   output word_t     ex_a_o,
   output word_t     ex_b_o,
   output word_t     ex_store_data_o,
   output mem_kind_e ex_mem_kind_o,
   output logic      ex_branch_o,
   output logic      ex_branch_ne_o,
   output word_t     ex_offset_o,
   output reg_idx_t  ex_dest_o,
   output logic      ex_wen_o
);

   instr_u    instr;
   alu_op_e   alu_op;
   mem_kind_e mem_kind;
   logic      is_branch;
   logic      use_imm;
   logic      zero_ext;
   logic      is_shift;
   logic      writes;
   reg_idx_t  dest;
   word_t     imm_ext;
   word_t     rs_val;
   word_t     rt_val;
   word_t     op_a;
   word_t     op_b;

   function automatic word_t select_src(fwd_sel_e sel, word_t rf, word_t ex, word_t mem);
      case (sel)
         FWD_EX:  return ex;
         FWD_MEM: return mem;
         default: return rf;
      endcase
   endfunction

   assign instr = instr_i;
   assign rs_o  = instr.r.rs;
   assign rt_o  = instr.r.rt;
   assign dest  = (instr.r.op == OP_RTYPE) ? instr.r.rd : instr.i.rt;

   assign zero_ext = instr.i.op inside {OP_ANDI, OP_ORI, OP_XORI};
   assign imm_ext  = zero_ext ? {16'h0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

   always_comb begin
      alu_op    = ALU_ADD;
      mem_kind  = MEM_NONE;
      is_branch = 1'b0;
      use_imm   = 1'b1;
      is_shift  = 1'b0;
      writes    = 1'b1;
      case (instr.r.op)
         OP_RTYPE: begin
            use_imm  = 1'b0;
            is_shift = instr.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
            case (instr.r.funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_NOR:  alu_op = ALU_NOR;
               FN_SLT:  alu_op = ALU_SLT;
               FN_SLTU: alu_op = ALU_SLTU;
               FN_SLL:  alu_op = ALU_SLL;
               FN_SRL:  alu_op = ALU_SRL;
               FN_SRA:  alu_op = ALU_SRA;
               default: writes = 1'b0;
            endcase
         end
         OP_ADDIU: alu_op = ALU_ADD;
         OP_SLTI:  alu_op = ALU_SLT;
         OP_ANDI:  alu_op = ALU_AND;
         OP_ORI:   alu_op = ALU_OR;
         OP_XORI:  alu_op = ALU_XOR;
         OP_LUI:   alu_op = ALU_LUI;
         OP_LW:    mem_kind = MEM_LOAD;
         OP_SW: begin
            mem_kind = MEM_STORE;
            writes   = 1'b0;
         end
         OP_BEQ, OP_BNE: begin
            is_branch = 1'b1;
            use_imm   = 1'b0;
            writes    = 1'b0;
         end
         // Unknown encodings become no-ops
         default: writes = 1'b0;
      endcase
   end

   assign rs_val = select_src(fwd_a_sel_i, rs_data_i, ex_fwd_i, mem_fwd_i);
   assign rt_val = select_src(fwd_b_sel_i, rt_data_i, ex_fwd_i, mem_fwd_i);

   // Shifts take rt as the value and shamt as the amount
   assign op_a = is_shift ? rt_val : rs_val;
   assign op_b = is_shift ? {27'd0, instr.r.shamt} : (use_imm ? imm_ext : rt_val);

   always_ff @(posedge clk) begin
      if (rst || stall_i) begin
         ex_mem_kind_o <= MEM_NONE;
         ex_branch_o   <= 1'b0;
         ex_wen_o      <= 1'b0;
      end else begin
         ex_mem_kind_o <= mem_kind;
         ex_branch_o   <= is_branch;
         ex_wen_o      <= writes && (dest != '0);
      end
   end

   always_ff @(posedge clk) begin
      ex_pc_o         <= pc_i;
      ex_alu_op_o     <= alu_op;
      ex_a_o          <= op_a;
      ex_b_o          <= op_b;
      ex_store_data_o <= rt_val;
      ex_branch_ne_o  <= (instr.i.op == OP_BNE);
      ex_offset_o     <= imm_ext;
      ex_dest_o       <= dest;
   end

endmodule

// ==== decode/hazard_unit.sv ====
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
   input  reg_idx_t  rs_i,
   input  reg_idx_t  rt_i,
   input  reg_idx_t  ex_dest_i,
   input  logic      ex_wen_i,
   input  mem_kind_e ex_mem_kind_i,
   input  reg_idx_t  mem_dest_i,
   input  logic      mem_wen_i,
   output fwd_sel_e  fwd_a_sel_o,
   output fwd_sel_e  fwd_b_sel_o,
   output logic      stall_o
);

   logic ex_load;

   // Execute is younger, so it wins over memory
   function automatic fwd_sel_e pick(logic ex_hit, logic mem_hit);
      if (ex_hit) begin
         return FWD_EX;
      end
      return mem_hit ? FWD_MEM : FWD_REGFILE;
   endfunction

   assign ex_load = ex_wen_i && (ex_mem_kind_i == MEM_LOAD);

   assign fwd_a_sel_o = pick(ex_wen_i && !ex_load && (ex_dest_i == rs_i),
                             mem_wen_i && (mem_dest_i == rs_i));
   assign fwd_b_sel_o = pick(ex_wen_i && !ex_load && (ex_dest_i == rt_i),
                             mem_wen_i && (mem_dest_i == rt_i));

   // Load data is not ready until the memory stage
   assign stall_o = ex_load && ((ex_dest_i == rs_i) || (ex_dest_i == rt_i));

endmodule

// ==== decode/reg_file.sv ====
module reg_file import isa_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t raddr_a_i,
   input  reg_idx_t raddr_b_i,
   input  logic     wen_i,
   input  reg_idx_t waddr_i,
   input  word_t    wdata_i,
   output word_t    rdata_a_o,
   output word_t    rdata_b_o
);

   word_t regs [REG_COUNT];

   // Same-cycle write wins over the stored value
   function automatic word_t read_port(reg_idx_t addr, logic wen, reg_idx_t waddr,
                                       word_t wdata, word_t stored);
      if (addr == '0) begin
         return '0;
      end
      return (wen && addr == waddr) ? wdata : stored;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wen_i) begin
         regs[waddr_i] <= wdata_i;
      end
   end

   assign rdata_a_o = read_port(raddr_a_i, wen_i, waddr_i, wdata_i, regs[raddr_a_i]);
   assign rdata_b_o = read_port(raddr_b_i, wen_i, waddr_i, wdata_i, regs[raddr_b_i]);

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  word_t     pc_i,
   input  alu_op_e   alu_op_i,
   input  word_t     a_i,
   input  word_t     b_i,
   input  word_t     store_data_i,
   input  mem_kind_e mem_kind_i,
   input  logic      branch_i,
   input  logic      branch_ne_i,
   input  word_t     offset_i,
   input  reg_idx_t  dest_i,
   input  logic      wen_i,
   output word_t     result_o,
   output logic      branch_taken_o,
   output word_t     branch_target_o,
   output logic      data_en_o,
   output logic      data_we_o,
   output word_t     data_addr_o,
   output word_t     data_wdata_o,
   output word_t     mem_pc_o,
   output word_t     mem_result_o,
   output logic      mem_is_load_o,
   output reg_idx_t  mem_dest_o,
   output logic      mem_wen_o
);

   word_t alu;

   always_comb begin
      case (alu_op_i)
         ALU_ADD:  alu = a_i + b_i;
         ALU_SUB:  alu = a_i - b_i;
         ALU_AND:  alu = a_i & b_i;
         ALU_OR:   alu = a_i | b_i;
         ALU_XOR:  alu = a_i ^ b_i;
         ALU_NOR:  alu = ~(a_i | b_i);
         ALU_SLT:  alu = {31'd0, $signed(a_i) < $signed(b_i)};
         ALU_SLTU: alu = {31'd0, a_i < b_i};
         ALU_SLL:  alu = a_i << b_i[4:0];
         ALU_SRL:  alu = a_i >> b_i[4:0];
         ALU_SRA:  alu = $signed(a_i) >>> b_i[4:0];
         ALU_LUI:  alu = {b_i[15:0], 16'h0};
         default:  alu = '0;
      endcase
   end

   assign result_o = alu;

   // Target is relative to the delay slot
   assign branch_taken_o  = branch_i && ((a_i == b_i) != branch_ne_i);
   assign branch_target_o = pc_i + 32'd4 + {offset_i[29:0], 2'b00};

   assign data_en_o    = (mem_kind_i != MEM_NONE);
   assign data_we_o    = (mem_kind_i == MEM_STORE);
   assign data_addr_o  = alu;
   assign data_wdata_o = store_data_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         mem_is_load_o <= 1'b0;
         mem_wen_o     <= 1'b0;
      end else begin
         mem_is_load_o <= (mem_kind_i == MEM_LOAD);
         mem_wen_o     <= wen_i;
      end
   end

   always_ff @(posedge clk) begin
      mem_pc_o     <= pc_i;
      mem_result_o <= alu;
      mem_dest_o   <= dest_i;
   end

endmodule

// ==== fetch/fetch_stage.sv ====
module fetch_stage import isa_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  stall_i,
   input  logic  branch_taken_i,
   input  word_t branch_target_i,
   input  word_t inst_data_i,
   output word_t inst_addr_o,
   output word_t id_pc_o,
   output word_t id_instr_o
);

   word_t pc;
   word_t id_pc;
   word_t replay;
   logic  replay_valid;
   logic  squash;

   assign inst_addr_o = pc;
   assign id_pc_o     = id_pc;

   // Squash covers the wrong-path slot and the stale word seen right after reset
   assign id_instr_o = squash ? '0 : (replay_valid ? replay : inst_data_i);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc           <= RESET_PC;
         replay_valid <= 1'b0;
         squash       <= 1'b1;
      end else begin
         if (branch_taken_i) begin
            pc <= branch_target_i;
         end else if (!stall_i) begin
            pc <= pc + 32'd4;
         end
         replay_valid <= stall_i;
         squash       <= branch_taken_i;
      end
   end

   // Memory is re-addressed with the held pc, so the stalled word is kept here
   always_ff @(posedge clk) begin
      if (stall_i) begin
         replay <= id_instr_o;
      end else begin
         id_pc <= pc;
      end
   end

endmodule

// ==== rtl/core_top.sv ====
module core_top import isa_pkg::*, pipe_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic     clk,
   input  logic     rst,
   output word_t    inst_addr_o,
   input  word_t    inst_data_i,
   output logic     data_en_o,
   output logic     data_we_o,
   output word_t    data_addr_o,
   output word_t    data_wdata_o,
   input  word_t    data_rdata_i,
   output word_t    wb_pc_o,
   output logic     wb_rf_wen_o,
   output reg_idx_t wb_rf_wnum_o,
   output word_t    wb_rf_wdata_o
);

   logic      stall;
   logic      branch_taken;
   word_t     branch_target;
   word_t     id_pc;
   word_t     id_instr;
   reg_idx_t  rs;
   reg_idx_t  rt;
   word_t     rs_data;
   word_t     rt_data;
   fwd_sel_e  fwd_a_sel;
   fwd_sel_e  fwd_b_sel;

   // Decode/execute register
   word_t     ex_pc;
   alu_op_e   ex_alu_op;
   word_t     ex_a;
   word_t     ex_b;
   word_t     ex_store_data;
   mem_kind_e ex_mem_kind;
   logic      ex_branch;
   logic      ex_branch_ne;
   word_t     ex_offset;
   reg_idx_t  ex_dest;
   logic      ex_wen;
   word_t     ex_result;

   // Execute/memory register
   word_t     mem_pc;
   word_t     mem_result;
   logic      mem_is_load;
   reg_idx_t  mem_dest;
   logic      mem_wen;
   word_t     mem_fwd;

   fetch_stage #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk             (clk),
      .rst             (rst),
      .stall_i         (stall),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .inst_data_i     (inst_data_i),
      .inst_addr_o     (inst_addr_o),
      .id_pc_o         (id_pc),
      .id_instr_o      (id_instr)
   );

   decode_stage u_decode (
      .clk             (clk),
      .rst             (rst),
      .stall_i         (stall),
      .pc_i            (id_pc),
      .instr_i         (id_instr),
      .rs_data_i       (rs_data),
      .rt_data_i       (rt_data),
      .ex_fwd_i        (ex_result),
      .mem_fwd_i       (mem_fwd),
      .fwd_a_sel_i     (fwd_a_sel),
      .fwd_b_sel_i     (fwd_b_sel),
      .rs_o            (rs),
      .rt_o            (rt),
      .ex_pc_o         (ex_pc),
      .ex_alu_op_o     (ex_alu_op),
      .ex_a_o          (ex_a),
      .ex_b_o          (ex_b),
      .ex_store_data_o (ex_store_data),
      .ex_mem_kind_o   (ex_mem_kind),
      .ex_branch_o     (ex_branch),
      .ex_branch_ne_o  (ex_branch_ne),
      .ex_offset_o     (ex_offset),
      .ex_dest_o       (ex_dest),
      .ex_wen_o        (ex_wen)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .rst       (rst),
      .raddr_a_i (rs),
      .raddr_b_i (rt),
      .wen_i     (wb_rf_wen_o),
      .waddr_i   (wb_rf_wnum_o),
      .wdata_i   (wb_rf_wdata_o),
      .rdata_a_o (rs_data),
      .rdata_b_o (rt_data)
   );

   hazard_unit u_hazard (
      .rs_i          (rs),
      .rt_i          (rt),
      .ex_dest_i     (ex_dest),
      .ex_wen_i      (ex_wen),
      .ex_mem_kind_i (ex_mem_kind),
      .mem_dest_i    (mem_dest),
      .mem_wen_i     (mem_wen),
      .fwd_a_sel_o   (fwd_a_sel),
      .fwd_b_sel_o   (fwd_b_sel),
      .stall_o       (stall)
   );

   execute_stage u_execute (
      .clk             (clk),
      .rst             (rst),
      .pc_i            (ex_pc),
      .alu_op_i        (ex_alu_op),
      .a_i             (ex_a),
      .b_i             (ex_b),
      .store_data_i    (ex_store_data),
      .mem_kind_i      (ex_mem_kind),
      .branch_i        (ex_branch),
      .branch_ne_i     (ex_branch_ne),
      .offset_i        (ex_offset),
      .dest_i          (ex_dest),
      .wen_i           (ex_wen),
      .result_o        (ex_result),
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target),
      .data_en_o       (data_en_o),
      .data_we_o       (data_we_o),
      .data_addr_o     (data_addr_o),
      .data_wdata_o    (data_wdata_o),
      .mem_pc_o        (mem_pc),
      .mem_result_o    (mem_result),
      .mem_is_load_o   (mem_is_load),
      .mem_dest_o      (mem_dest),
      .mem_wen_o       (mem_wen)
   );

   mem_wb_stage u_mem_wb (
      .clk          (clk),
      .rst          (rst),
      .pc_i         (mem_pc),
      .result_i     (mem_result),
      .is_load_i    (mem_is_load),
      .dest_i       (mem_dest),
      .wen_i        (mem_wen),
      .data_rdata_i (data_rdata_i),
      .fwd_o        (mem_fwd),
      .wb_pc_o      (wb_pc_o),
      .wb_wen_o     (wb_rf_wen_o),
      .wb_dest_o    (wb_rf_wnum_o),
      .wb_data_o    (wb_rf_wdata_o)
   );

endmodule

// ==== rtl/mem_wb_stage.sv ====
module mem_wb_stage import isa_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  word_t    pc_i,
   input  word_t    result_i,
   input  logic     is_load_i,
   input  reg_idx_t dest_i,
   input  logic     wen_i,
   input  word_t    data_rdata_i,
   output word_t    fwd_o,
   output word_t    wb_pc_o,
   output logic     wb_wen_o,
   output reg_idx_t wb_dest_o,
   output word_t    wb_data_o
);

   // Read data arrives while the load sits in this stage
   assign fwd_o = is_load_i ? data_rdata_i : result_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_wen_o <= 1'b0;
      end else begin
         wb_wen_o <= wen_i;
      end
   end

   // Writeback value doubles as the trace output
   always_ff @(posedge clk) begin
      wb_pc_o   <= pc_i;
      wb_dest_o <= dest_i;
      wb_data_o <= fwd_o;
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module core_tb \
   -Mdir obj_dir -o core_sim || { echo "Build failed"; exit 1; }

./obj_dir/core_sim > sim.log 2>&1
cat sim.log

grep -qx "Testbench passed" sim.log && echo "Simulation OK" || { echo "Simulation FAILED"; exit 1; }

// ==== tb/core_properties.sv ====
module core_properties import isa_pkg::*; (
   input logic     clk,
   input logic     rst,
   input word_t    inst_addr_i,
   input logic     data_en_i,
   input logic     data_we_i,
   input logic     wb_rf_wen_i,
   input reg_idx_t wb_rf_wnum_i
);

   // Register 0 is never written
   assert property (@(posedge clk) disable iff (rst) wb_rf_wen_i |-> wb_rf_wnum_i != '0)
      else $error("register write to r0");

   assert property (@(posedge clk) disable iff (rst) data_we_i |-> data_en_i)
      else $error("data write without enable");

   assert property (@(posedge clk) disable iff (rst) inst_addr_i[1:0] == 2'b00)
      else $error("fetch address not word aligned");

   assert property (@(posedge clk) $fell(rst) |-> !data_en_i && !data_we_i && !wb_rf_wen_i)
      else $error("control outputs active after reset");

endmodule

bind core_top core_properties u_properties (
   .clk          (clk),
   .rst          (rst),
   .inst_addr_i  (inst_addr_o),
   .data_en_i    (data_en_o),
   .data_we_i    (data_we_o),
   .wb_rf_wen_i  (wb_rf_wen_o),
   .wb_rf_wnum_i (wb_rf_wnum_o)
);

// ==== tb/ref_model.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// ISA-level model of the program in rom, with one branch delay slot
function automatic void run_reference();
   word_t    regs [REG_COUNT];
   word_t    mem [256];
   word_t    pc;
   word_t    npc;
   word_t    nnpc;
   word_t    a;
   word_t    b;
   word_t    res;
   word_t    sext;
   word_t    zext;
   word_t    addr;
   instr_u   w;
   logic     wr;
   reg_idx_t dst;
   int       steps;

   foreach (regs[i]) regs[i] = '0;
   foreach (mem[i]) mem[i] = ram_fill(i);
   exp_pc.delete();
   exp_num.delete();
   exp_val.delete();
   exp_addr.delete();
   exp_data.delete();
   pc    = RESET_PC;
   npc   = RESET_PC + 32'd4;
   steps = 0;
   while (steps < 4000) begin
      w = rom[pc[9:2]];
      // Self loop ends the program, its delay slot is a no-op
      if (w == TERM_WORD) break;
      a    = regs[w.r.rs];
      b    = regs[w.r.rt];
      sext = {{16{w.i.imm[15]}}, w.i.imm};
      zext = {16'h0, w.i.imm};
      addr = a + sext;
      wr   = 1'b1;
      dst  = w.i.rt;
      res  = '0;
      nnpc = npc + 32'd4;
      case (w.r.op)
         OP_RTYPE: begin
            dst = w.r.rd;
            case (w.r.funct)
               FN_ADDU: res = a + b;
               FN_SUBU: res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_XOR:  res = a ^ b;
               FN_NOR:  res = ~(a | b);
               FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
               FN_SLTU: res = {31'd0, a < b};
               FN_SLL:  res = b << w.r.shamt;
               FN_SRL:  res = b >> w.r.shamt;
               FN_SRA:  res = $signed(b) >>> w.r.shamt;
               default: wr = 1'b0;
            endcase
         end
         OP_ADDIU: res = a + sext;
         OP_SLTI:  res = {31'd0, $signed(a) < $signed(sext)};
         OP_ANDI:  res = a & zext;
         OP_ORI:   res = a | zext;
         OP_XORI:  res = a ^ zext;
         OP_LUI:   res = {w.i.imm, 16'h0};
         OP_LW:    res = mem[addr[9:2]];
         OP_SW: begin
            wr = 1'b0;
            mem[addr[9:2]] = b;
            exp_addr.push_back(addr);
            exp_data.push_back(b);
         end
         OP_BEQ, OP_BNE: begin
            wr = 1'b0;
            if ((a == b) == (w.r.op == OP_BEQ)) begin
               nnpc = npc + {sext[29:0], 2'b00};
            end
         end
         default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin
         regs[dst] = res;
         exp_pc.push_back(pc);
         exp_num.push_back(dst);
         exp_val.push_back(res);
      end
      pc    = npc;
      npc   = nnpc;
      steps = steps + 1;
   end
endfunction

`endif

// ==== tb/core_tb.sv ====
module core_tb import isa_pkg::*; ();

   localparam word_t RESET_PC     = '0;
   localparam int    NUM_PROGRAMS = 3;
   localparam int    RUN_TIMEOUT  = 4000;
   localparam word_t TERM_WORD    = {OP_BEQ, 5'd0, 5'd0, 16'hffff};
   localparam logic [5:0] R_FNS [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                         FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
   localparam logic [5:0] I_OPS [6] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

   logic     clk;
   logic     rst;
   word_t    inst_addr;
   word_t    inst_data;
   logic     data_en;
   logic     data_we;
   word_t    data_addr;
   word_t    data_wdata;
   word_t    data_rdata;
   word_t    wb_pc;
   logic     wb_wen;
   reg_idx_t wb_num;
   word_t    wb_data;

   word_t    rom [256];
   word_t    ram [256];
   integer   seed = 97;
   int       prog_len;
   bit       checking = 1'b0;

   word_t    exp_pc [$];
   reg_idx_t exp_num [$];
   word_t    exp_val [$];
   word_t    exp_addr [$];
   word_t    exp_data [$];

   function automatic word_t ram_fill(int i);
      logic [7:0] a;
      a = 8'(i);
      return {a, ~a, a ^ 8'h5a, 8'hc3};
   endfunction

   `include "ref_model.svh"

   core_top #(
      .RESET_PC (RESET_PC)
   ) DUT (
      .clk           (clk),
      .rst           (rst),
      .inst_addr_o   (inst_addr),
      .inst_data_i   (inst_data),
      .data_en_o     (data_en),
      .data_we_o     (data_we),
      .data_addr_o   (data_addr),
      .data_wdata_o  (data_wdata),
      .data_rdata_i  (data_rdata),
      .wb_pc_o       (wb_pc),
      .wb_rf_wen_o   (wb_wen),
      .wb_rf_wnum_o  (wb_num),
      .wb_rf_wdata_o (wb_data)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // Synchronous memories, one cycle read latency
   always @(posedge clk) begin
      inst_data <= #1 rom[inst_addr[9:2]];
      if (data_en && data_we) begin
         ram[data_addr[9:2]] <= data_wdata;
      end else if (data_en) begin
         data_rdata <= #1 ram[data_addr[9:2]];
      end
   end

   task automatic stop_on_error(string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1, "stopping at first error");
   endtask

   function automatic int urand(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic word_t enc_r(logic [5:0] fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                   logic [4:0] sh);
      return {OP_RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt,
                                   logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t random_alu();
      int       k;
      reg_idx_t s;
      reg_idx_t t;
      reg_idx_t d;
      k = urand(17);
      s = reg_idx_t'(urand(8));
      t = reg_idx_t'(urand(8));
      d = reg_idx_t'(urand(8));
      if (k < 11) begin
         if (R_FNS[k] inside {FN_SLL, FN_SRL, FN_SRA}) begin
            return enc_r(R_FNS[k], 5'd0, t, d, 5'(urand(32)));
         end
         return enc_r(R_FNS[k], s, t, d, 5'd0);
      end
      if (I_OPS[k-11] == OP_LUI) begin
         s = 5'd0;
      end
      return enc_i(I_OPS[k-11], s, d, 16'(urand(65536)));
   endfunction

   task automatic emit(word_t w);
      rom[prog_len] = w;
      prog_len = prog_len + 1;
   endtask

   task automatic build_program();
      int       k;
      reg_idx_t d;
      foreach (rom[i]) rom[i] = '0;
      prog_len = 0;
      repeat (40) emit(random_alu());
      // Chains reaching back one, two and three instructions
      repeat (8) begin
         emit(enc_i(OP_ADDIU, 5'd3, 5'd3, 16'(urand(65536))));
         emit(enc_r(FN_ADDU, 5'd3, 5'd4, 5'd4, 5'd0));
         emit(enc_r(FN_SUBU, 5'd4, 5'd3, 5'd5, 5'd0));
         emit(enc_r(FN_XOR, 5'd5, 5'd3, 5'd6, 5'd0));
      end
      repeat (12) begin
         k = urand(64);
         d = reg_idx_t'(1 + urand(7));
         emit(enc_i(OP_SW, 5'd0, reg_idx_t'(1 + urand(7)), 16'(4 * k)));
         emit(enc_i(OP_LW, 5'd0, d, 16'(4 * k)));
         emit(enc_r(FN_ADDU, d, d, reg_idx_t'(urand(8)), 5'd0));
         emit(enc_i(OP_SW, 5'd0, d, 16'(4 * urand(64))));
         emit(enc_i(OP_LW, 5'd0, reg_idx_t'(1 + urand(7)), 16'(4 * urand(64))));
      end
      // Branch, delay slot, wrong-path marker, then the target
      repeat (12) begin
         emit(enc_i(urand(2) != 0 ? OP_BEQ : OP_BNE, reg_idx_t'(urand(4)),
                    reg_idx_t'(urand(4)), 16'd2));
         emit(random_alu());
         emit(enc_i(OP_ADDIU, 5'd0, 5'd7, 16'h7bad));
         emit(random_alu());
      end
      emit(TERM_WORD);
      emit('0);
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      assert (inst_addr == RESET_PC && !wb_wen && !data_en)
         else stop_on_error($sformatf("CHECK FAILED at time %0t: reset state, pc %h",
                                      $time, inst_addr));
      @(posedge clk);
      #1 rst = 1'b0;
   endtask

   // Compares trace and store ports with the next expected entries
   always @(negedge clk) begin
      if (checking && wb_wen) begin
         assert (exp_pc.size() > 0)
            else stop_on_error($sformatf("CHECK FAILED at time %0t: extra write r%0d pc %h",
                                         $time, wb_num, wb_pc));
         assert (wb_pc == exp_pc[0] && wb_num == exp_num[0] && wb_data == exp_val[0])
            else stop_on_error($sformatf(
               "CHECK FAILED at time %0t: write pc %h r%0d=%h, expected pc %h r%0d=%h",
               $time, wb_pc, wb_num, wb_data, exp_pc[0], exp_num[0], exp_val[0]));
         void'(exp_pc.pop_front());
         void'(exp_num.pop_front());
         void'(exp_val.pop_front());
      end
      if (checking && data_en && data_we) begin
         assert (exp_addr.size() > 0)
            else stop_on_error($sformatf("CHECK FAILED at time %0t: extra store to %h",
                                         $time, data_addr));
         assert (data_addr == exp_addr[0] && data_wdata == exp_data[0])
            else stop_on_error($sformatf(
               "CHECK FAILED at time %0t: store %h to %h, expected %h to %h",
               $time, data_wdata, data_addr, exp_data[0], exp_addr[0]));
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
      end
   end

   initial begin
      int cycles;
      rst        = 1'b1;
      inst_data  = '0;
      data_rdata = '0;
      for (int p = 0; p < NUM_PROGRAMS; p++) begin
         build_program();
         foreach (ram[i]) ram[i] = ram_fill(i);
         run_reference();
         checking = 1'b0;
         apply_reset();
         checking = 1'b1;
         cycles = 0;
         while ((exp_pc.size() != 0 || exp_addr.size() != 0) && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles = cycles + 1;
         end
         if (cycles >= RUN_TIMEOUT) begin
            stop_on_error($sformatf("Timeout: program %0d still had %0d writes pending",
                                    p, exp_pc.size() + exp_addr.size()));
         end
         // Core spins on the final loop, nothing more may be written
         repeat (10) @(posedge clk);
         #1;
      end
      $display("Testbench passed");
      $finish;
   end

endmodule
